// ==== include/exec_macros.svh ====
//==========================================================================
// Width and constant definitions for the execute stage.
// Included by the package and by every module that sizes a vector or
// needs the link offset.
//==========================================================================

`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// width of a data word and of every operand path
`define EXEC_DATA_W 32

// shift amount, taken from the low bits of the A operand
`define EXEC_SHAMT_W 5

// link address is the PC of the branch plus this offset
`define EXEC_LINK_OFFSET 4

`endif

// ==== hdl/exec_pkg.sv ====
//==========================================================================
// Shared types for the execute stage: word and shift-amount vectors,
// the ALU operation code and the operand and forwarding selects.
// Modules import it in their body and use scoped names in port lists.
//==========================================================================

`include "exec_macros.svh"

package exec_pkg;

    typedef logic [`EXEC_DATA_W-1:0] word_t;    // one data word
    typedef logic [`EXEC_SHAMT_W-1:0] shamt_t;  // shift distance

    // operation for the result stage
    typedef enum logic [4:0] {
        ALU_PA   = 5'd0,    // pass A
        ALU_PB   = 5'd1,    // pass B
        ALU_ADD  = 5'd2,
        ALU_SUB  = 5'd3,
        ALU_SUBU = 5'd4,
        ALU_OR   = 5'd5,
        ALU_AND  = 5'd6,
        ALU_XOR  = 5'd7,
        ALU_NOR  = 5'd8,
        ALU_SLT  = 5'd9,    // signed compare
        ALU_SLTU = 5'd10,   // unsigned compare
        ALU_SLL  = 5'd11,
        ALU_SRL  = 5'd12,
        ALU_SRA  = 5'd13,
        ALU_NOP  = 5'd14
    } alu_op_t;

    typedef enum logic [1:0] {
        A_RS   = 2'd0,      // forwarded rs
        A_LINK = 2'd1,      // pc + link offset
        A_EXT  = 2'd2,      // extended immediate
        A_SPC  = 2'd3       // saved pc
    } src_a_t;

    typedef enum logic [1:0] {
        B_RT  = 2'd0,       // forwarded rt
        B_EXT = 2'd1        // extended immediate
    } src_b_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,    // register file value
        FWD_ALU  = 2'd1,    // result of the alu stage
        FWD_MEM  = 2'd2     // result of the memory stage
    } fwd_t;

endpackage

// ==== hdl/alu_logic.sv ====
//==========================================================================
// Combinational arithmetic, logic and compare unit. Drives zero for any
// operation it does not own, so its output can be ORed with the shifter.
//==========================================================================

`include "exec_macros.svh"

module alu_logic (
    input  exec_pkg::word_t    a_i,
    input  exec_pkg::word_t    b_i,
    input  exec_pkg::alu_op_t  op_i,
    output exec_pkg::word_t    y_o
);

    import exec_pkg::*;

    localparam int W = `EXEC_DATA_W;

    word_t      diff;
    logic [W:0] slt_diff;

    // a - b as a + ~b + 1, wraps modulo 2^32
    assign diff = a_i + ~b_i + 1'b1;

    // sign-extended to 33 bits so the top bit is the true sign of a - b
    assign slt_diff = {a_i[W-1], a_i} + {~b_i[W-1], ~b_i} + 1'b1;

    always_comb
    begin
        case (op_i)
            ALU_PA:
                y_o = a_i;
            ALU_PB:
                y_o = b_i;
            ALU_ADD:
                y_o = a_i + b_i;
            ALU_SUB,
            ALU_SUBU:
                y_o = diff;     // no overflow trap here
            ALU_OR:
                y_o = a_i | b_i;
            ALU_AND:
                y_o = a_i & b_i;
            ALU_XOR:
                y_o = a_i ^ b_i;
            ALU_NOR:
                y_o = ~(a_i | b_i);
            ALU_SLT:
                y_o = word_t'(slt_diff[W]);
            ALU_SLTU:
                y_o = word_t'(a_i < b_i);
            default:
                y_o = '0;       // shifts and nop
        endcase
    end

endmodule

// ==== hdl/barrel_shifter.sv ====
//==========================================================================
// Five-level logarithmic shifter for SLL, SRL and SRA. Left shifts run
// through the right-shift levels on a bit-reversed word.
// Output is zero for every other operation.
//==========================================================================

`include "exec_macros.svh"

module barrel_shifter (
    input  exec_pkg::word_t    value_i,
    input  exec_pkg::shamt_t   amount_i,
    input  exec_pkg::alu_op_t  op_i,
    output exec_pkg::word_t    y_o
);

    import exec_pkg::*;

    localparam int W      = `EXEC_DATA_W;
    localparam int LEVELS = `EXEC_SHAMT_W;

    logic  is_shift;
    logic  is_left;
    logic  fill;
    word_t level [0:LEVELS];

    function automatic word_t bit_rev(word_t x);
        word_t r;
        for (int i = 0; i < W; i++)
            r[i] = x[W-1-i];
        return r;
    endfunction

    assign is_shift = (op_i == ALU_SLL) || (op_i == ALU_SRL) || (op_i == ALU_SRA);
    assign is_left  = (op_i == ALU_SLL);
    assign fill     = (op_i == ALU_SRA) && value_i[W-1];  // sign bit for sra only

    assign level[0] = is_left ? bit_rev(value_i) : value_i;

    // level i moves the word right by 2^i when amount bit i is set
    for (genvar i = 0; i < LEVELS; i++)
    begin : g_level
        localparam int STEP = 1 << i;
        assign level[i+1] = amount_i[i] ? {{STEP{fill}}, level[i][W-1:STEP]}
                                        : level[i];
    end

    always_comb
    begin
        if (!is_shift)
            y_o = '0;
        else if (is_left)
            y_o = bit_rev(level[LEVELS]);   // undo the reversal
        else
            y_o = level[LEVELS];
    end

endmodule

// ==== hdl/operand_select.sv ====
//==========================================================================
// First execute stage. Resolves forwarding for rs, rt and store data,
// picks the A and B operands and keeps the clearable saved-PC register.
// Operands, operation and valid are registered for the result stage.
//==========================================================================

`include "exec_macros.svh"

module operand_select (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_i,
    input  exec_pkg::alu_op_t  alu_op_i,
    input  exec_pkg::src_a_t   src_a_i,
    input  exec_pkg::src_b_t   src_b_i,
    input  exec_pkg::fwd_t     fwd_a_i,
    input  exec_pkg::fwd_t     fwd_b_i,
    input  exec_pkg::fwd_t     fwd_st_i,
    input  logic               spc_clr_i,
    input  exec_pkg::word_t    rs_i,
    input  exec_pkg::word_t    rt_i,
    input  exec_pkg::word_t    ext_i,
    input  exec_pkg::word_t    pc_i,
    input  exec_pkg::word_t    fw_alu_i,
    input  exec_pkg::word_t    fw_mem_i,
    output logic               valid_o,
    output exec_pkg::alu_op_t  alu_op_o,
    output exec_pkg::word_t    a_o,
    output exec_pkg::word_t    b_o,
    output exec_pkg::word_t    store_o,
    output exec_pkg::word_t    spc_o
);

    import exec_pkg::*;

    word_t rs_fwd;
    word_t rt_fwd;
    word_t st_fwd;
    word_t link_addr;
    word_t a_sel;
    word_t b_sel;

    // same bypass rule for every register operand
    function automatic word_t fwd_pick(fwd_t sel, word_t reg_val,
                                       word_t alu_val, word_t mem_val);
        word_t pick;
        case (sel)
            FWD_ALU: pick = alu_val;
            FWD_MEM: pick = mem_val;
            default: pick = reg_val;    // FWD_NONE
        endcase
        return pick;
    endfunction

    assign rs_fwd = fwd_pick(fwd_a_i, rs_i, fw_alu_i, fw_mem_i);
    assign rt_fwd = fwd_pick(fwd_b_i, rt_i, fw_alu_i, fw_mem_i);
    assign st_fwd = fwd_pick(fwd_st_i, rt_i, fw_alu_i, fw_mem_i);

    assign link_addr = pc_i + word_t'(`EXEC_LINK_OFFSET);   // return address

    always_comb
    begin
        case (src_a_i)
            A_LINK:  a_sel = link_addr;
            A_EXT:   a_sel = ext_i;
            A_SPC:   a_sel = spc_o;     // value before this edge
            default: a_sel = rs_fwd;
        endcase
    end

    assign b_sel = (src_b_i == B_EXT) ? ext_i : rt_fwd;

    // saved pc, clear wins over load
    always_ff @(posedge clk)
    begin
        if (!rst)
            spc_o <= '0;
        else if (spc_clr_i)
            spc_o <= '0;
        else if (valid_i)
            spc_o <= pc_i;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            valid_o  <= 1'b0;
            alu_op_o <= ALU_NOP;
        end
        else
        begin
            valid_o <= valid_i;
            if (valid_i)
                alu_op_o <= alu_op_i;
        end
    end

    // operands hold while the stage is idle
    always_ff @(posedge clk)
    begin
        if (valid_i)
        begin
            a_o     <= a_sel;
            b_o     <= b_sel;
            store_o <= st_fwd;
        end
    end

    a_fwd_known: assert property (@(posedge clk) disable iff (!rst)
        valid_i |-> !$isunknown({fwd_a_i, fwd_b_i, fwd_st_i}))
        else $error("forwarding select unknown on a valid instruction");

endmodule

// ==== hdl/result_stage.sv ====
//==========================================================================
// Second execute stage. Merges the ALU and shifter outputs and registers
// the result with the store data and the valid bit.
//==========================================================================

`include "exec_macros.svh"

module result_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_i,
    input  exec_pkg::alu_op_t  op_i,
    input  exec_pkg::word_t    a_i,
    input  exec_pkg::word_t    b_i,
    input  exec_pkg::word_t    store_i,
    output logic               valid_o,
    output exec_pkg::word_t    result_o,
    output exec_pkg::word_t    store_data_o
);

    import exec_pkg::*;

    word_t alu_y;
    word_t shift_y;

    alu_logic i_alu (
        .a_i  (a_i),
        .b_i  (b_i),
        .op_i (op_i),
        .y_o  (alu_y)
    );

    // shifts B by the low bits of A
    barrel_shifter i_shifter (
        .value_i  (b_i),
        .amount_i (a_i[`EXEC_SHAMT_W-1:0]),
        .op_i     (op_i),
        .y_o      (shift_y)
    );

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            valid_o      <= 1'b0;
            result_o     <= '0;
            store_data_o <= '0;
        end
        else
        begin
            valid_o <= valid_i;
            if (valid_i)
            begin
                result_o     <= alu_y | shift_y;    // units zero when not selected
                store_data_o <= store_i;
            end
        end
    end

    a_units_exclusive: assert property (@(posedge clk) disable iff (!rst)
        valid_i |-> ((alu_y == '0) || (shift_y == '0)))
        else $error("alu and shifter both drove a nonzero result");

endmodule

// ==== hdl/exec_stage.sv ====
//==========================================================================
// Execute stage top level. Operand select feeds the result stage, giving
// a result two cycles after an instruction is accepted.
//==========================================================================

module exec_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_i,
    input  exec_pkg::alu_op_t  alu_op_i,
    input  exec_pkg::src_a_t   src_a_i,
    input  exec_pkg::src_b_t   src_b_i,
    input  exec_pkg::fwd_t     fwd_a_i,
    input  exec_pkg::fwd_t     fwd_b_i,
    input  exec_pkg::fwd_t     fwd_st_i,
    input  logic               spc_clr_i,
    input  exec_pkg::word_t    rs_i,
    input  exec_pkg::word_t    rt_i,
    input  exec_pkg::word_t    ext_i,
    input  exec_pkg::word_t    pc_i,
    input  exec_pkg::word_t    fw_alu_i,
    input  exec_pkg::word_t    fw_mem_i,
    output logic               valid_o,
    output exec_pkg::word_t    result_o,
    output exec_pkg::word_t    store_data_o,
    output exec_pkg::word_t    spc_o
);

    import exec_pkg::*;

    logic    op_valid;
    alu_op_t op_alu;
    word_t   op_a;
    word_t   op_b;
    word_t   op_store;

    operand_select i_operand_select (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (valid_i),
        .alu_op_i  (alu_op_i),
        .src_a_i   (src_a_i),
        .src_b_i   (src_b_i),
        .fwd_a_i   (fwd_a_i),
        .fwd_b_i   (fwd_b_i),
        .fwd_st_i  (fwd_st_i),
        .spc_clr_i (spc_clr_i),
        .rs_i      (rs_i),
        .rt_i      (rt_i),
        .ext_i     (ext_i),
        .pc_i      (pc_i),
        .fw_alu_i  (fw_alu_i),
        .fw_mem_i  (fw_mem_i),
        .valid_o   (op_valid),
        .alu_op_o  (op_alu),
        .a_o       (op_a),
        .b_o       (op_b),
        .store_o   (op_store),
        .spc_o     (spc_o)
    );

    result_stage i_result_stage (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (op_valid),
        .op_i         (op_alu),
        .a_i          (op_a),
        .b_i          (op_b),
        .store_i      (op_store),
        .valid_o      (valid_o),
        .result_o     (result_o),
        .store_data_o (store_data_o)
    );

endmodule

// ==== bench/exec_checker.sv ====
//==========================================================================
// Output monitor for the execute stage testbench. Holds the queue of
// expected results, compares result, store data and saved PC whenever
// valid_o is seen and keeps the pass and fail counts.
//==========================================================================

module exec_checker (
    input  logic             clk,
    input  logic             valid_i,
    input  exec_pkg::word_t  result_i,
    input  exec_pkg::word_t  store_data_i,
    input  exec_pkg::word_t  spc_i
);

    timeunit 1ns;
    timeprecision 100ps;

    import exec_pkg::*;

    string exp_name [$];
    word_t exp_res [$];
    word_t exp_st [$];
    word_t exp_spc [$];
    int    exp_due [$];
    int    cyc = 0;
    int    pending = 0;
    int    passes = 0;
    int    fails = 0;

    // due cycle is the sampling edge that sees the two-cycle result
    task automatic push_exp(string name, word_t res, word_t st, word_t spc);
        exp_name.push_back(name);
        exp_res.push_back(res);
        exp_st.push_back(st);
        exp_spc.push_back(spc);
        exp_due.push_back(cyc + 3);
        pending++;
    endtask

    task automatic compare(string name, string what, word_t exp, word_t act, inout int bad);
        if (exp !== act)
        begin
            $display("ERROR %s %s expected %h actual %h", name, what, exp, act);
            bad++;
        end
    endtask

    always @(posedge clk)
    begin
        int bad;
        string name;
        cyc++;
        if (valid_i === 1'b1)
        begin
            if (pending == 0)
            begin
                $display("valid output seen at cycle %0d with no instruction pending", cyc);
                fails++;
            end
            else
            begin
                bad  = 0;
                name = exp_name.pop_front();
                compare(name, "result", exp_res.pop_front(), result_i, bad);
                compare(name, "store_data", exp_st.pop_front(), store_data_i, bad);
                compare(name, "spc", exp_spc.pop_front(), spc_i, bad);
                if (exp_due.pop_front() != cyc)
                begin
                    $display("%s came out at cycle %0d, not two cycles after input", name, cyc);
                    bad++;
                end
                pending--;
                if (bad == 0)
                begin
                    $display("ok    %s", name);
                    passes++;
                end
                else
                    fails++;
            end
        end
    end

    task automatic report();
        $display("tests run %0d, passed %0d, failed %0d", passes + fails, passes, fails);
    endtask

endmodule

// ==== bench/exec_tb.sv ====
//==========================================================================
// Testbench for the execute stage. Builds a table of fixed and random
// rows, computes expected values with a reference model and drives one
// row per cycle. exec_checker compares the outputs.
//==========================================================================

`include "exec_macros.svh"

module exec_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import exec_pkg::*;

    localparam word_t FW_ALU = 32'ha5a5_0001;
    localparam word_t FW_MEM = 32'h5a5a_0002;
    localparam word_t RS0    = 32'h1111_1111;
    localparam word_t RT0    = 32'h2222_2222;

    logic    clk;
    logic    rst;
    logic    valid_i;
    alu_op_t alu_op_i;
    src_a_t  src_a_i;
    src_b_t  src_b_i;
    fwd_t    fwd_a_i;
    fwd_t    fwd_b_i;
    fwd_t    fwd_st_i;
    logic    spc_clr_i;
    word_t   rs_i;
    word_t   rt_i;
    word_t   ext_i;
    word_t   pc_i;
    word_t   fw_alu_i;
    word_t   fw_mem_i;
    logic    valid_o;
    word_t   result_o;
    word_t   store_data_o;
    word_t   spc_o;

    // stimulus table, one entry per cycle slot
    string   t_name [$];
    logic    t_v [$];
    alu_op_t t_op [$];
    src_a_t  t_sa [$];
    src_b_t  t_sb [$];
    fwd_t    t_fa [$];
    fwd_t    t_fb [$];
    fwd_t    t_fs [$];
    logic    t_clr [$];
    word_t   t_rs [$];
    word_t   t_rt [$];
    word_t   t_res [$];
    word_t   t_st [$];
    word_t   t_spc [$];

    exec_stage i_dut (.*);

    exec_checker i_checker (
        .clk          (clk),
        .valid_i      (valid_o),
        .result_i     (result_o),
        .store_data_i (store_data_o),
        .spc_i        (spc_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t ext_of(int k);
        return 32'h0000_8000 ^ (k * 32'h0101);
    endfunction

    function automatic word_t pc_of(int k);
        return 32'h0040_0000 + 4 * k;
    endfunction

    task automatic add_row(string name, logic v, alu_op_t op, src_a_t sa, src_b_t sb,
                           fwd_t fa, fwd_t fb, fwd_t fs, logic clr, word_t rs, word_t rt);
        t_name.push_back(name);
        t_v.push_back(v);
        t_op.push_back(op);
        t_sa.push_back(sa);
        t_sb.push_back(sb);
        t_fa.push_back(fa);
        t_fb.push_back(fb);
        t_fs.push_back(fs);
        t_clr.push_back(clr);
        t_rs.push_back(rs);
        t_rt.push_back(rt);
    endtask

    task automatic add_op(string name, alu_op_t op, word_t a, word_t b);
        add_row(name, 1'b1, op, A_RS, B_RT, FWD_NONE, FWD_NONE, FWD_NONE, 1'b0, a, b);
    endtask

    function automatic word_t ref_fwd(fwd_t sel, word_t reg_val);
        if (sel == FWD_ALU)
            return FW_ALU;
        if (sel == FWD_MEM)
            return FW_MEM;
        return reg_val;
    endfunction

    function automatic word_t ref_alu(alu_op_t op, word_t a, word_t b);
        case (op)
            ALU_PA:   return a;
            ALU_PB:   return b;
            ALU_ADD:  return a + b;
            ALU_SUB,
            ALU_SUBU: return a - b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return b << a[4:0];
            ALU_SRL:  return b >> a[4:0];
            ALU_SRA:  return word_t'($signed(b) >>> a[4:0]);
            default:  return '0;
        endcase
    endfunction

    // walks the table once, tracking the saved pc slot by slot
    task automatic build_expected();
        word_t spc;
        word_t a;
        word_t b;
        word_t spc_after [$];
        int    n;
        spc = '0;
        for (int k = 0; k < t_name.size(); k++)
        begin
            case (t_sa[k])
                A_LINK:  a = pc_of(k) + `EXEC_LINK_OFFSET;
                A_EXT:   a = ext_of(k);
                A_SPC:   a = spc;
                default: a = ref_fwd(t_fa[k], t_rs[k]);
            endcase
            b = (t_sb[k] == B_EXT) ? ext_of(k) : ref_fwd(t_fb[k], t_rt[k]);
            t_res.push_back(ref_alu(t_op[k], a, b));
            t_st.push_back(ref_fwd(t_fs[k], t_rt[k]));
            if (t_clr[k])
                spc = '0;
            else if (t_v[k])
                spc = pc_of(k);
            spc_after.push_back(spc);
        end
        n = spc_after.size();
        for (int k = 0; k < n; k++)
            t_spc.push_back(spc_after[(k + 1 < n) ? k + 1 : n - 1]);  // idle after the end
    endtask

    task automatic build_table();
        add_op("pa", ALU_PA, 32'hdead_beef, 32'h1234_5678);
        add_op("pb", ALU_PB, 32'hdead_beef, 32'h1234_5678);
        add_op("add_wrap", ALU_ADD, 32'hffff_fff0, 32'h0000_0020);
        add_op("sub_neg", ALU_SUB, 32'd3, 32'd5);
        add_op("subu", ALU_SUBU, 32'h8000_0000, 32'd1);
        add_op("or", ALU_OR, 32'hf0f0_0000, 32'h0f0f_00ff);
        add_op("and", ALU_AND, 32'hf0f0_ffff, 32'h0ff0_1234);
        add_op("xor", ALU_XOR, 32'haaaa_5555, 32'hffff_0000);
        add_op("nor", ALU_NOR, 32'h0000_ff00, 32'h00f0_000f);
        add_op("slt_neg_pos", ALU_SLT, 32'hffff_ffff, 32'd1);
        add_op("slt_pos_neg", ALU_SLT, 32'd1, 32'hffff_ffff);
        add_op("sltu_big_small", ALU_SLTU, 32'hffff_ffff, 32'd1);
        add_op("sltu_small_big", ALU_SLTU, 32'd1, 32'hffff_ffff);
        add_op("nop", ALU_NOP, 32'h1234_5678, 32'h9abc_def0);
        add_op("sll_0", ALU_SLL, 32'd0, 32'h8765_4321);
        add_op("sll_1", ALU_SLL, 32'd1, 32'h8765_4321);
        add_op("sll_31", ALU_SLL, 32'd31, 32'h8765_4321);
        add_op("srl_0", ALU_SRL, 32'd0, 32'h8765_4321);
        add_op("srl_1_low_bits", ALU_SRL, 32'h0000_0021, 32'h8765_4321);
        add_op("srl_31", ALU_SRL, 32'd31, 32'h8765_4321);
        add_op("sra_neg_0", ALU_SRA, 32'd0, 32'h8765_4321);
        add_op("sra_neg_1", ALU_SRA, 32'd1, 32'h8765_4321);
        add_op("sra_neg_31", ALU_SRA, 32'd31, 32'h8765_4321);
        add_op("sra_pos_4", ALU_SRA, 32'd4, 32'h7765_4321);
        add_row("fwd_a_alu", 1, ALU_PA, A_RS, B_RT, FWD_ALU, FWD_NONE, FWD_NONE, 0, RS0, RT0);
        add_row("fwd_a_mem", 1, ALU_PA, A_RS, B_RT, FWD_MEM, FWD_NONE, FWD_ALU, 0, RS0, RT0);
        add_row("fwd_b_alu", 1, ALU_PB, A_RS, B_RT, FWD_NONE, FWD_ALU, FWD_MEM, 0, RS0, RT0);
        add_row("fwd_b_mem", 1, ALU_PB, A_RS, B_RT, FWD_NONE, FWD_MEM, FWD_NONE, 0, RS0, RT0);
        add_row("src_link", 1, ALU_PA, A_LINK, B_RT, FWD_NONE, FWD_NONE, FWD_NONE, 0, RS0, RT0);
        add_row("src_a_ext", 1, ALU_PA, A_EXT, B_RT, FWD_NONE, FWD_NONE, FWD_NONE, 0, RS0, RT0);
        add_row("src_b_ext", 1, ALU_PB, A_RS, B_EXT, FWD_NONE, FWD_NONE, FWD_NONE, 0, RS0, RT0);
        add_row("src_spc", 1, ALU_PA, A_SPC, B_RT, FWD_NONE, FWD_NONE, FWD_NONE, 0, RS0, RT0);
        add_row("idle", 0, ALU_NOP, A_RS, B_RT, FWD_NONE, FWD_NONE, FWD_NONE, 0, RS0, RT0);
        add_row("spc_after_idle", 1, ALU_PA, A_SPC, B_RT, FWD_NONE, FWD_NONE, FWD_NONE, 0, RS0, RT0);
        add_row("spc_clear", 1, ALU_PA, A_SPC, B_RT, FWD_NONE, FWD_NONE, FWD_NONE, 1, RS0, RT0);
        add_row("spc_zero", 1, ALU_PA, A_SPC, B_RT, FWD_NONE, FWD_NONE, FWD_NONE, 0, RS0, RT0);
        for (int k = 0; k < 16; k++)
            add_row($sformatf("rand_%0d", k), ($urandom_range(7, 0) != 0),
                    alu_op_t'($urandom_range(14, 0)), src_a_t'($urandom_range(3, 0)),
                    src_b_t'($urandom_range(1, 0)), fwd_t'($urandom_range(2, 0)),
                    fwd_t'($urandom_range(2, 0)), fwd_t'($urandom_range(2, 0)),
                    ($urandom_range(7, 0) == 0), $urandom(), $urandom());
    endtask

    // watchdog, rows plus margin, two cycles each
    initial
    begin
        #1;
        #((t_name.size() + 10) * 40);
        $display("timeout, results did not arrive in time");
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        void'($urandom(32'hd0fd_c6dd));
        rst       = 1'b0;
        valid_i   = 1'b0;
        alu_op_i  = ALU_NOP;
        src_a_i   = A_RS;
        src_b_i   = B_RT;
        fwd_a_i   = FWD_NONE;
        fwd_b_i   = FWD_NONE;
        fwd_st_i  = FWD_NONE;
        spc_clr_i = 1'b0;
        rs_i      = '0;
        rt_i      = '0;
        ext_i     = '0;
        pc_i      = '0;
        fw_alu_i  = FW_ALU;
        fw_mem_i  = FW_MEM;
        build_table();
        build_expected();
        repeat (5) @(negedge clk);
        rst = 1'b1;
        for (int k = 0; k < t_name.size(); k++)
        begin
            @(negedge clk);
            valid_i   = t_v[k];
            alu_op_i  = t_op[k];
            src_a_i   = t_sa[k];
            src_b_i   = t_sb[k];
            fwd_a_i   = t_fa[k];
            fwd_b_i   = t_fb[k];
            fwd_st_i  = t_fs[k];
            spc_clr_i = t_clr[k];
            rs_i      = t_rs[k];
            rt_i      = t_rt[k];
            ext_i     = ext_of(k);
            pc_i      = pc_of(k);
            if (t_v[k])
                i_checker.push_exp(t_name[k], t_res[k], t_st[k], t_spc[k]);
        end
        @(negedge clk);
        valid_i   = 1'b0;
        spc_clr_i = 1'b0;
        wait (i_checker.pending == 0);
        repeat (4) @(negedge clk);  // catch stray valid outputs
        i_checker.report();
        if (i_checker.fails == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
hdl/exec_pkg.sv
hdl/alu_logic.sv
hdl/barrel_shifter.sv
hdl/operand_select.sv
hdl/result_stage.sv
hdl/exec_stage.sv
bench/exec_checker.sv
bench/exec_tb.sv
